//--- msx_glue_pkg.sv
package msx_glue_pkg;

   // ========================================
   // Menu status word layout
   // ========================================
   localparam int STATUS_W       = 64;

   localparam int ST_RESET       = 0;
   localparam int ST_ASPECT_LO   = 1;
   localparam int ST_SCALE_LO    = 3;
   localparam int ST_VSCALE_LO   = 6;
   localparam int ST_CAS_REWIND  = 9;
   localparam int ST_DETACH      = 10;
   localparam int ST_RESET_MOUNT = 12;
   localparam int ST_RESET_OSD   = 21;
   localparam int ST_CAS_SRC     = 40;

   // Loader index of a CAS file, low 6 bits only
   localparam logic [5:0] CAS_IOCTL_INDEX = 6'd5;

   // Display size that turns the crop on
   localparam logic [11:0] HD_WIDTH   = 12'd1920;
   localparam logic [11:0] HD_HEIGHT  = 12'd1080;
   localparam logic [11:0] CROP_LINES = 12'd216;

   // ========================================
   // Shared structures
   // ========================================
   typedef struct packed {
      logic [1:0] aspect;
      logic [2:0] scale;
      logic [2:0] vscale;
      logic       cas_rewind;
      logic       detach;
      logic       reset_mount;
      logic       cas_src_adc;
      logic       reset_osd;
   } menu_opts_t;

   // One request on an SDRAM channel
   typedef struct packed {
      logic [26:0] addr;
      logic [7:0]  din;
      logic        req;
      logic        rnw;
   } sdram_req_t;

   typedef struct packed {
      logic [27:0] addr;
      logic        rd;
   } ddr_rd_t;

   // Settings for the scaler and the mixer
   typedef struct packed {
      logic [1:0]  vga_sl;
      logic        scandoubler;
      logic        hq2x;
      logic [11:0] arx;
      logic [11:0] ary;
      logic [11:0] crop_size;
      logic [2:0]  vscale;
      logic [2:0]  reserved;
   } video_cfg_t;

endpackage

//--- core_control.sv
`timescale 1ns/1ps

module core_control
   import msx_glue_pkg::*;
(
   input  logic                clock_bus,
   input  logic                rst_n,
   input  logic [STATUS_W-1:0] status,
   input  logic                board_reset,
   input  logic                upload_reset,
   input  logic                fdc_enable,
   input  logic                img_mounted_fdc,
   output menu_opts_t          opts,
   output logic                hard_reset,
   output logic                core_reset
);

   logic hard_reset_d;
   logic mount_reset;
   logic core_reset_d;

   // ========================================
   // Status word unpacking
   // ========================================
   always_comb begin
      opts.aspect      = status[ST_ASPECT_LO +: 2];
      opts.scale       = status[ST_SCALE_LO +: 3];
      opts.vscale      = status[ST_VSCALE_LO +: 3];
      opts.cas_rewind  = status[ST_CAS_REWIND];
      opts.detach      = status[ST_DETACH];
      opts.reset_mount = status[ST_RESET_MOUNT];
      opts.cas_src_adc = status[ST_CAS_SRC];
      opts.reset_osd   = status[ST_RESET_OSD];
   end

   // ========================================
   // Reset generation
   // ========================================
   // Hard reset also restarts the loader path
   assign hard_reset_d = board_reset | status[ST_RESET] | upload_reset;

   // Restart after a floppy mount, only with the FDC present
   assign mount_reset = opts.reset_mount & img_mounted_fdc & fdc_enable;

   assign core_reset_d = hard_reset_d | opts.detach | opts.reset_osd | mount_reset;

   // Both resets held active while rst_n is low
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         hard_reset <= 1'b1;
         core_reset <= 1'b1;
      end else begin
         hard_reset <= hard_reset_d;
         core_reset <= core_reset_d;
      end
   end

endmodule

//--- sd_route.sv
`timescale 1ns/1ps

module sd_route #(
   parameter int ACT_TIMEOUT = 1000000
) (
   input  logic       clock_bus,
   input  logic       rst_n,
   input  logic       img_mounted_sd,
   input  logic       img_nonzero,
   input  logic       spi_sclk,
   input  logic       spi_mosi,
   input  logic       card_miso,
   input  logic       virt_miso,
   output logic       spi_miso,
   output logic       sd_cs,
   output logic       sd_sck,
   output logic       sd_mosi,
   output logic       led_user,
   output logic [1:0] led_disk
);

   localparam int CNT_W = $clog2(ACT_TIMEOUT + 1);
   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(ACT_TIMEOUT);

   logic             vsd_sel;
   logic             old_mosi;
   logic             old_miso;
   logic             toggle;
   logic [CNT_W-1:0] act_cnt;
   logic             sd_act;

   // ========================================
   // Card selection
   // ========================================
   // Virtual card takes over when a nonempty image is mounted
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted_sd) begin
         vsd_sel <= img_nonzero;
      end
   end

   assign spi_miso = vsd_sel ? virt_miso : card_miso;

   // Physical card is parked while the image is in use
   assign sd_cs   = vsd_sel;
   assign sd_sck  = spi_sclk & ~vsd_sel;
   assign sd_mosi = spi_mosi & ~vsd_sel;

   // ========================================
   // Activity timer
   // ========================================
   assign toggle = (old_mosi ^ spi_mosi) | (old_miso ^ spi_miso);

   // Retriggerable, saturates at the timeout
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         old_mosi <= 1'b0;
         old_miso <= 1'b0;
         act_cnt  <= CNT_MAX;
         sd_act   <= 1'b0;
      end else begin
         old_mosi <= spi_mosi;
         old_miso <= spi_miso;
         sd_act   <= act_cnt < CNT_MAX;
         if (toggle) begin
            act_cnt <= '0;
         end else if (act_cnt < CNT_MAX) begin
            act_cnt <= act_cnt + 1'b1;
         end
      end
   end

   // Upper disk LED bit gives the LED to this logic alone
   assign led_user = vsd_sel & sd_act;
   assign led_disk = {1'b1, ~vsd_sel & sd_act};

endmodule

//--- cas_control.sv
`timescale 1ns/1ps

module cas_control
   import msx_glue_pkg::*;
(
   input  logic        clock_bus,
   input  logic        rst_n,
   input  menu_opts_t  opts,
   input  logic        core_reset,
   input  logic        ioctl_download,
   input  logic [15:0] ioctl_index,
   input  logic        motor,
   input  logic        cas_dout,
   input  logic        adc_bit,
   input  logic        adc_active,
   output logic        cas_enable,
   output logic        cas_play,
   output logic        cas_rewind,
   output logic        tape_in
);

   logic cas_dl;
   logic cas_dl_q;

   // Only the low index bits name the file type
   assign cas_dl = ioctl_download & (ioctl_index[5:0] == CAS_IOCTL_INDEX);

   // ========================================
   // Tape loaded flag
   // ========================================
   // Set at the end of a CAS download and kept until power-on reset
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         cas_dl_q   <= 1'b0;
         cas_enable <= 1'b0;
      end else begin
         cas_dl_q <= cas_dl;
         if (cas_dl_q && !cas_dl) begin
            cas_enable <= 1'b1;
         end
      end
   end

   // Motor relay is active low
   assign cas_play = ~motor & cas_enable;

   // New file or core restart starts the tape over
   assign cas_rewind = opts.cas_rewind | cas_dl | core_reset;

   // Tape input from the file player or the ADC
   assign tape_in = opts.cas_src_adc ? (adc_active & adc_bit) : cas_dout;

endmodule

//--- mem_route.sv
`timescale 1ns/1ps

module mem_route
   import msx_glue_pkg::*;
(
   input  logic       dl_request,
   input  ddr_rd_t    dl_rd,
   input  ddr_rd_t    cas_rd,
   output ddr_rd_t    ddr_rd,
   input  logic       upload,
   input  sdram_req_t upload_req,
   input  sdram_req_t cpu_req,
   output sdram_req_t ch1_req,
   input  logic       cpu_sdram_ce,
   input  logic [7:0] sdram_dout,
   output logic [7:0] cpu_dout
);

   // ========================================
   // DDR3 read port
   // ========================================
   // Downloader has the port while it asks, the tape player otherwise
   assign ddr_rd = dl_request ? dl_rd : cas_rd;

   // ========================================
   // SDRAM channel 1
   // ========================================
   always_comb begin
      if (upload) begin
         ch1_req     = upload_req;
         // Upload only ever writes
         ch1_req.rnw = 1'b0;
      end else begin
         ch1_req = cpu_req;
      end
   end

   // Unselected SDRAM reads back as an open bus
   assign cpu_dout = cpu_sdram_ce ? sdram_dout : 8'hFF;

endmodule

//--- video_opts.sv
`timescale 1ns/1ps

module video_opts
   import msx_glue_pkg::*;
(
   input  logic        clock_bus,
   input  logic        rst_n,
   input  menu_opts_t  opts,
   input  logic        forced_sd,
   input  logic [11:0] hdmi_width,
   input  logic [11:0] hdmi_height,
   output video_cfg_t  cfg
);

   logic [2:0] sl;
   logic       scandoubler;
   logic       en216p;

   // Scanline level sits one step above the hq2x choice
   assign sl          = (opts.scale != 3'd0) ? opts.scale - 3'd1 : 3'd0;
   assign scandoubler = forced_sd | (opts.scale != 3'd0);

   // ========================================
   // Crop for a 1080p display
   // ========================================
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         en216p <= 1'b0;
      end else begin
         en216p <= (hdmi_width == HD_WIDTH) && (hdmi_height == HD_HEIGHT) && !scandoubler;
      end
   end

   always_comb begin
      cfg.vga_sl      = sl[1:0];
      cfg.scandoubler = scandoubler;
      cfg.hq2x        = opts.scale == 3'd1;
      // Aspect 0 is the original 4:3, others pick a stretch mode
      cfg.arx         = (opts.aspect == 2'd0) ? 12'd4 : {10'b0, opts.aspect - 2'd1};
      cfg.ary         = (opts.aspect == 2'd0) ? 12'd3 : 12'd0;
      cfg.crop_size   = en216p ? CROP_LINES : 12'd0;
      cfg.vscale      = opts.vscale;
      cfg.reserved    = 3'b000;
   end

endmodule

//--- msx_glue_top.sv
`timescale 1ns/1ps

module msx_glue_top
   import msx_glue_pkg::*;
#(
   parameter int ACT_TIMEOUT = 1000000
) (
   input  logic                clock_bus,
   input  logic                rst_n,
   // Reset and menu
   input  logic [STATUS_W-1:0] status,
   input  logic                board_reset,
   input  logic                upload_reset,
   input  logic                fdc_enable,
   input  logic                img_mounted_fdc,
   output menu_opts_t          opts,
   output logic                hard_reset,
   output logic                core_reset,
   // SD card
   input  logic                img_mounted_sd,
   input  logic                img_nonzero,
   input  logic                spi_sclk,
   input  logic                spi_mosi,
   input  logic                card_miso,
   input  logic                virt_miso,
   output logic                spi_miso,
   output logic                sd_cs,
   output logic                sd_sck,
   output logic                sd_mosi,
   output logic                led_user,
   output logic [1:0]          led_disk,
   // Cassette
   input  logic                ioctl_download,
   input  logic [15:0]         ioctl_index,
   input  logic                motor,
   input  logic                cas_dout,
   input  logic                adc_bit,
   input  logic                adc_active,
   output logic                cas_enable,
   output logic                cas_play,
   output logic                cas_rewind,
   output logic                tape_in,
   // Memory
   input  logic                dl_request,
   input  ddr_rd_t             dl_rd,
   input  ddr_rd_t             cas_rd,
   output ddr_rd_t             ddr_rd,
   input  logic                upload,
   input  sdram_req_t          upload_req,
   input  sdram_req_t          cpu_req,
   output sdram_req_t          ch1_req,
   input  logic                cpu_sdram_ce,
   input  logic [7:0]          sdram_dout,
   output logic [7:0]          cpu_dout,
   // Video
   input  logic                forced_sd,
   input  logic [11:0]         hdmi_width,
   input  logic [11:0]         hdmi_height,
   output video_cfg_t          cfg
);

   core_control i_core_control (
      .clock_bus       (clock_bus),
      .rst_n           (rst_n),
      .status          (status),
      .board_reset     (board_reset),
      .upload_reset    (upload_reset),
      .fdc_enable      (fdc_enable),
      .img_mounted_fdc (img_mounted_fdc),
      .opts            (opts),
      .hard_reset      (hard_reset),
      .core_reset      (core_reset)
   );

   sd_route #(
      .ACT_TIMEOUT (ACT_TIMEOUT)
   ) i_sd_route (
      .clock_bus      (clock_bus),
      .rst_n          (rst_n),
      .img_mounted_sd (img_mounted_sd),
      .img_nonzero    (img_nonzero),
      .spi_sclk       (spi_sclk),
      .spi_mosi       (spi_mosi),
      .card_miso      (card_miso),
      .virt_miso      (virt_miso),
      .spi_miso       (spi_miso),
      .sd_cs          (sd_cs),
      .sd_sck         (sd_sck),
      .sd_mosi        (sd_mosi),
      .led_user       (led_user),
      .led_disk       (led_disk)
   );

   cas_control i_cas_control (
      .clock_bus      (clock_bus),
      .rst_n          (rst_n),
      .opts           (opts),
      .core_reset     (core_reset),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .motor          (motor),
      .cas_dout       (cas_dout),
      .adc_bit        (adc_bit),
      .adc_active     (adc_active),
      .cas_enable     (cas_enable),
      .cas_play       (cas_play),
      .cas_rewind     (cas_rewind),
      .tape_in        (tape_in)
   );

   mem_route i_mem_route (
      .dl_request   (dl_request),
      .dl_rd        (dl_rd),
      .cas_rd       (cas_rd),
      .ddr_rd       (ddr_rd),
      .upload       (upload),
      .upload_req   (upload_req),
      .cpu_req      (cpu_req),
      .ch1_req      (ch1_req),
      .cpu_sdram_ce (cpu_sdram_ce),
      .sdram_dout   (sdram_dout),
      .cpu_dout     (cpu_dout)
   );

   video_opts i_video_opts (
      .clock_bus   (clock_bus),
      .rst_n       (rst_n),
      .opts        (opts),
      .forced_sd   (forced_sd),
      .hdmi_width  (hdmi_width),
      .hdmi_height (hdmi_height),
      .cfg         (cfg)
   );

endmodule

//--- msx_glue_props.sv
`timescale 1ns/1ps

module msx_glue_props (
   input logic clock_bus,
   input logic rst_n,
   input logic vsd_sel,
   input logic sd_sck,
   input logic sd_mosi,
   input logic cas_enable
);

   // Physical card parked while the image is in use
   a_card_parked : assert property (@(posedge clock_bus) disable iff (!rst_n)
      vsd_sel |-> (sd_sck == 1'b0 && sd_mosi == 1'b0))
      else $error("SD clock or data driven while the virtual card is selected");

   // Tape loaded flag only clears on rst_n
   a_cas_sticky : assert property (@(posedge clock_bus) disable iff (!rst_n)
      $past(cas_enable) |-> cas_enable)
      else $error("cas_enable fell while rst_n was high");

endmodule

bind sd_route msx_glue_props i_sd_props (
   .clock_bus  (clock_bus),
   .rst_n      (rst_n),
   .vsd_sel    (vsd_sel),
   .sd_sck     (sd_sck),
   .sd_mosi    (sd_mosi),
   .cas_enable (1'b0)
);

bind cas_control msx_glue_props i_cas_props (
   .clock_bus  (clock_bus),
   .rst_n      (rst_n),
   .vsd_sel    (1'b0),
   .sd_sck     (1'b0),
   .sd_mosi    (1'b0),
   .cas_enable (cas_enable)
);

//--- tb_msx_glue.sv
`timescale 1ns/1ps

module tb_msx_glue
   import msx_glue_pkg::*;
;

   localparam int ACT_TIMEOUT = 40;
   localparam int MAX_CYCLES  = 4000;

   typedef struct packed {
      menu_opts_t opts;
      logic       hard_reset;
      logic       core_reset;
      logic       spi_miso;
      logic       sd_cs;
      logic       sd_sck;
      logic       sd_mosi;
      logic       led_user;
      logic [1:0] led_disk;
      logic       cas_enable;
      logic       cas_play;
      logic       cas_rewind;
      logic       tape_in;
      ddr_rd_t    ddr_rd;
      sdram_req_t ch1_req;
      logic [7:0] cpu_dout;
      video_cfg_t cfg;
   } outs_t;

   logic clock_bus;
   logic rst_n;
   logic [STATUS_W-1:0] status;
   logic board_reset, upload_reset, fdc_enable, img_mounted_fdc;
   logic img_mounted_sd, img_nonzero, spi_sclk, spi_mosi, card_miso, virt_miso;
   logic ioctl_download, motor, cas_dout, adc_bit, adc_active;
   logic [15:0] ioctl_index;
   logic dl_request, upload, cpu_sdram_ce, forced_sd;
   ddr_rd_t dl_rd, cas_rd, ddr_rd;
   sdram_req_t upload_req, cpu_req, ch1_req;
   logic [7:0] sdram_dout, cpu_dout;
   logic [11:0] hdmi_width, hdmi_height;
   menu_opts_t opts;
   logic hard_reset, core_reset, spi_miso, sd_cs, sd_sck, sd_mosi, led_user;
   logic [1:0] led_disk;
   logic cas_enable, cas_play, cas_rewind, tape_in;
   video_cfg_t cfg;

   // Reference state, advanced once per rising edge
   logic m_hard, m_core, m_vsd, m_old_mosi, m_old_miso, m_sd_act;
   logic m_cas_q, m_cas_en, m_en216p;
   int m_cnt;
   outs_t exp_o;
   logic [31:0] seed;
   int cycles;

   msx_glue_top #(.ACT_TIMEOUT(ACT_TIMEOUT)) i_dut (.*);

   initial begin
      clock_bus = 1'b0;
      forever #20 clock_bus = ~clock_bus;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic draw(output logic [31:0] v);
      seed = lcg_next(seed);
      v = seed;
   endtask

   // ========================================
   // Reference model
   // ========================================
   function automatic outs_t expected_outputs();
      outs_t e;
      logic [2:0] scale;
      logic [1:0] aspect;
      logic cas_dl;
      scale  = status[5:3];
      aspect = status[2:1];
      cas_dl = ioctl_download && (ioctl_index[5:0] == 6'd5);
      e.opts.aspect      = aspect;
      e.opts.scale       = scale;
      e.opts.vscale      = status[8:6];
      e.opts.cas_rewind  = status[9];
      e.opts.detach      = status[10];
      e.opts.reset_mount = status[12];
      e.opts.cas_src_adc = status[40];
      e.opts.reset_osd   = status[21];
      e.hard_reset = m_hard;
      e.core_reset = m_core;
      e.spi_miso   = m_vsd ? virt_miso : card_miso;
      e.sd_cs      = m_vsd;
      e.sd_sck     = m_vsd ? 1'b0 : spi_sclk;
      e.sd_mosi    = m_vsd ? 1'b0 : spi_mosi;
      e.led_user   = m_vsd && m_sd_act;
      e.led_disk   = {1'b1, !m_vsd && m_sd_act};
      e.cas_enable = m_cas_en;
      e.cas_play   = !motor && m_cas_en;
      e.cas_rewind = status[9] || cas_dl || m_core;
      e.tape_in    = status[40] ? (adc_active && adc_bit) : cas_dout;
      e.ddr_rd     = dl_request ? dl_rd : cas_rd;
      e.ch1_req    = upload ? upload_req : cpu_req;
      if (upload) begin
         e.ch1_req.rnw = 1'b0;
      end
      e.cpu_dout = cpu_sdram_ce ? sdram_dout : 8'hFF;
      e.cfg.vga_sl      = (scale == 3'd0) ? 2'd0 : 2'(scale - 3'd1);
      e.cfg.scandoubler = forced_sd || (scale != 3'd0);
      e.cfg.hq2x        = scale == 3'd1;
      e.cfg.arx         = (aspect == 2'd0) ? 12'd4 : 12'(aspect) - 12'd1;
      e.cfg.ary         = (aspect == 2'd0) ? 12'd3 : 12'd0;
      e.cfg.crop_size   = m_en216p ? 12'd216 : 12'd0;
      e.cfg.vscale      = status[8:6];
      e.cfg.reserved    = 3'b000;
      return e;
   endfunction

   task automatic update_model();
      logic sel_miso;
      logic toggle;
      logic cas_dl;
      sel_miso = m_vsd ? virt_miso : card_miso;
      toggle   = (m_old_mosi ^ spi_mosi) | (m_old_miso ^ sel_miso);
      cas_dl   = ioctl_download && (ioctl_index[5:0] == 6'd5);
      if (!rst_n) begin
         {m_hard, m_core} = 2'b11;
         {m_vsd, m_old_mosi, m_old_miso, m_sd_act} = 4'b0000;
         {m_cas_q, m_cas_en, m_en216p} = 3'b000;
         m_cnt = ACT_TIMEOUT;
      end else begin
         m_sd_act   = m_cnt < ACT_TIMEOUT;
         m_cnt      = toggle ? 0 : ((m_cnt < ACT_TIMEOUT) ? m_cnt + 1 : m_cnt);
         m_old_mosi = spi_mosi;
         m_old_miso = sel_miso;
         if (img_mounted_sd) begin
            m_vsd = img_nonzero;
         end
         m_hard = board_reset || status[0] || upload_reset;
         m_core = m_hard || status[10] || status[21] ||
                  (status[12] && img_mounted_fdc && fdc_enable);
         if (m_cas_q && !cas_dl) begin
            m_cas_en = 1'b1;
         end
         m_cas_q  = cas_dl;
         m_en216p = (hdmi_width == 12'd1920) && (hdmi_height == 12'd1080) &&
                    !(forced_sd || (status[5:3] != 3'd0));
      end
   endtask

   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      assert (got === exp) else begin
         $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
         $display("Errors found");
         $fatal(1, "Output mismatch");
      end
   endtask

   task automatic require(input logic cond, input string what);
      assert (cond) else begin
         $display("%0t ns %s", $time, what);
         $display("Errors found");
         $fatal(1, "Directed check failed");
      end
   endtask

   // Inputs are stable here and registers have just moved
   always @(posedge clock_bus) begin
      #1;
      update_model();
      exp_o = expected_outputs();
      compare_value("opts", 64'(opts), 64'(exp_o.opts));
      compare_value("hard_reset", 64'(hard_reset), 64'(exp_o.hard_reset));
      compare_value("core_reset", 64'(core_reset), 64'(exp_o.core_reset));
      compare_value("spi_miso", 64'(spi_miso), 64'(exp_o.spi_miso));
      compare_value("sd_cs", 64'(sd_cs), 64'(exp_o.sd_cs));
      compare_value("sd_sck", 64'(sd_sck), 64'(exp_o.sd_sck));
      compare_value("sd_mosi", 64'(sd_mosi), 64'(exp_o.sd_mosi));
      compare_value("led_user", 64'(led_user), 64'(exp_o.led_user));
      compare_value("led_disk", 64'(led_disk), 64'(exp_o.led_disk));
      compare_value("cas_enable", 64'(cas_enable), 64'(exp_o.cas_enable));
      compare_value("cas_play", 64'(cas_play), 64'(exp_o.cas_play));
      compare_value("cas_rewind", 64'(cas_rewind), 64'(exp_o.cas_rewind));
      compare_value("tape_in", 64'(tape_in), 64'(exp_o.tape_in));
      compare_value("ddr_rd", 64'(ddr_rd), 64'(exp_o.ddr_rd));
      compare_value("ch1_req", 64'(ch1_req), 64'(exp_o.ch1_req));
      compare_value("cpu_dout", 64'(cpu_dout), 64'(exp_o.cpu_dout));
      compare_value("cfg", 64'(cfg), 64'(exp_o.cfg));
   end

   // Run limit of about twice the test length
   initial begin
      cycles = 0;
      forever begin
         @(posedge clock_bus);
         cycles++;
         if (cycles >= MAX_CYCLES) begin
            $display("Timeout, the tests did not finish in %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $fatal(1, "Timeout");
         end
      end
   end

   // ========================================
   // Stimulus
   // ========================================
   task automatic clear_inputs();
      status = '0;
      {board_reset, upload_reset, fdc_enable, img_mounted_fdc} = 4'b0000;
      {img_mounted_sd, img_nonzero, spi_sclk, spi_mosi, card_miso, virt_miso} = 6'b0;
      {ioctl_download, motor, cas_dout, adc_bit, adc_active} = 5'b0;
      ioctl_index = 16'd0;
      {dl_request, upload, cpu_sdram_ce, forced_sd} = 4'b0000;
      dl_rd = '0;
      cas_rd = '0;
      upload_req = '0;
      cpu_req = '0;
      sdram_dout = 8'd0;
      hdmi_width = 12'd0;
      hdmi_height = 12'd0;
   endtask

   task automatic randomize_inputs();
      logic [31:0] w0, w1, w2, w3, w4, w5, w6;
      draw(w0);
      draw(w1);
      draw(w2);
      draw(w3);
      draw(w4);
      draw(w5);
      draw(w6);
      status          = {w0, w1};
      board_reset     = w2[31:29] == 3'd0;
      upload_reset    = w2[28:26] == 3'd0;
      fdc_enable      = w2[25];
      img_mounted_fdc = w2[24];
      img_mounted_sd  = w2[23:20] == 4'd0;
      img_nonzero     = w2[19];
      spi_sclk        = w2[18];
      spi_mosi        = w2[17];
      card_miso       = w2[16];
      virt_miso       = w2[15];
      ioctl_download  = w2[14];
      // Upper index bits carry no file type
      ioctl_index     = {w6[9:0], (w2[13] ? 6'd5 : 6'd4)};
      {motor, cas_dout, adc_bit, adc_active} = w2[12:9];
      {dl_request, upload, cpu_sdram_ce} = w2[8:6];
      forced_sd       = w3[31:29] == 3'd0;
      dl_rd           = w3[28:0];
      cas_rd          = w4[28:0];
      upload_req      = {w3, w4[31:27]};
      cpu_req         = {w5, w1[31:27]};
      sdram_dout      = w4[26:19];
      hdmi_width      = w2[2] ? 12'd1920 : w5[11:0];
      hdmi_height     = w2[2] ? 12'd1080 : w5[23:12];
   endtask

   initial begin
      seed  = 32'd97;
      rst_n = 1'b0;
      clear_inputs();
      repeat (16) @(negedge clock_bus);
      rst_n = 1'b1;

      // Cassette flag with the wrong index first
      ioctl_index    = 16'd4;
      ioctl_download = 1'b1;
      repeat (4) @(negedge clock_bus);
      ioctl_download = 1'b0;
      repeat (2) @(negedge clock_bus);
      require(!cas_enable, "cas_enable was set by a download with index 4");
      ioctl_index    = 16'd5;
      ioctl_download = 1'b1;
      repeat (4) @(negedge clock_bus);
      require(!cas_enable, "cas_enable was set before the cassette download ended");
      ioctl_download = 1'b0;
      repeat (2) @(negedge clock_bus);
      require(cas_enable, "cas_enable stayed low after a cassette download");

      // Mount a nonzero image and let the timer run out
      img_nonzero    = 1'b1;
      img_mounted_sd = 1'b1;
      @(negedge clock_bus);
      img_mounted_sd = 1'b0;
      repeat (50) @(negedge clock_bus);
      require(sd_cs, "virtual card was not selected after the mount");
      spi_mosi = 1'b1;
      repeat (3) @(negedge clock_bus);
      require(led_user, "led_user did not light within 3 clocks of a mosi toggle");
      repeat (44) @(negedge clock_bus);
      require(!led_user && led_disk == 2'b10, "activity LEDs still lit after 44 quiet clocks");

      // Every scale and aspect on a 1080p display
      hdmi_width  = 12'd1920;
      hdmi_height = 12'd1080;
      for (int s = 0; s < 8; s++) begin
         for (int a = 0; a < 4; a++) begin
            status = '0;
            status[5:3] = 3'(s);
            status[2:1] = 2'(a);
            repeat (2) @(negedge clock_bus);
            if (s == 0) begin
               require(cfg.crop_size == 12'd216, "crop_size not 216 on 1080p without doubler");
            end
         end
      end

      repeat (1500) begin
         randomize_inputs();
         @(negedge clock_bus);
      end
      $display("No errors");
      $finish;
   end

endmodule

//--- verilog.f
msx_glue_pkg.sv
core_control.sv
sd_route.sv
cas_control.sv
mem_route.sv
video_opts.sv
msx_glue_top.sv
msx_glue_props.sv
tb_msx_glue.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_msx_glue \
   -f verilog.f -o tb_msx_glue
./obj_dir/tb_msx_glue
